// ==== verilog/emu_pkg.sv ====
package emu_pkg;

    // ram word and address
    localparam int CFG_DW = 64;
    localparam int RAM_AW = 5;   // 32 words

    // pattern word fields, top bit down
    localparam int PCK_CNTW = 30;
    localparam int RATIOW   = 7;    // enough for 100
    localparam int PCK_SIZW = 14;
    localparam int DEST_W   = 8;
    localparam int CLASS_W  = 4;
    // last-entry flag sits in bit 0

    // extra repeats live in the low bits of word 0
    localparam int REPEAT_W = 32;

    // full injection ratio, one bit wider than the ratio field
    localparam logic [RATIOW:0] MAX_RATIO = 100;

    // ram layout
    localparam logic [RAM_AW-1:0] REPEAT_ADDR        = 0;
    localparam logic [RAM_AW-1:0] PATTERN_START_ADDR = 1;

    // statistics readout
    localparam int STAT_AW = 2;
    localparam logic [STAT_AW-1:0] STAT_SENT      = 0;
    localparam logic [STAT_AW-1:0] STAT_RCVD      = 1;
    localparam logic [STAT_AW-1:0] STAT_TOTAL_LAT = 2;
    localparam logic [STAT_AW-1:0] STAT_WORST_LAT = 3;

    localparam int LAT_W = 16;

    typedef enum logic [2:0] {
        IDLE,
        WAIT1,   // ram address settling
        WAIT2,   // ram data settling
        SEND,
        DONE
    } seq_state_e;

endpackage

// ==== verilog/pattern_if.sv ====
`timescale 1ns/1ps

interface pattern_if
    import emu_pkg::*;
();
    logic                entry_valid;   // level, high in SEND only
    logic [PCK_CNTW-1:0] pck_num;
    logic [RATIOW-1:0]   ratio;
    logic [PCK_SIZW-1:0] size;
    logic [DEST_W-1:0]   dest;
    logic [CLASS_W-1:0]  pck_class;
    logic                entry_done;    // one-cycle pulse back to the sequencer

    modport seq (
        output entry_valid, pck_num, ratio, size, dest, pck_class,
        input  entry_done
    );

    modport inj (
        input  entry_valid, pck_num, ratio, size, dest, pck_class,
        output entry_done
    );
endinterface

// ==== verilog/pattern_ram.sv ====
`timescale 1ns/1ps

module pattern_ram
    import emu_pkg::*;
(
    input  logic              clk,
    // port a, sequencer side
    input  logic [RAM_AW-1:0] addr_a_i,
    output logic [CFG_DW-1:0] q_a_o,
    // port b, host side
    input  logic              we_b_i,
    input  logic [RAM_AW-1:0] addr_b_i,
    input  logic [CFG_DW-1:0] data_b_i,
    output logic [CFG_DW-1:0] q_b_o
);
    logic [CFG_DW-1:0] mem [0:(1 << RAM_AW) - 1];

    always_ff @(posedge clk) begin
        q_a_o <= mem[addr_a_i];   // read only
    end

    // host port, read returns old data on a write cycle
    always_ff @(posedge clk) begin
        if (we_b_i) begin
            mem[addr_b_i] <= data_b_i;
        end
        q_b_o <= mem[addr_b_i];
    end

endmodule

// ==== verilog/pattern_sequencer.sv ====
`timescale 1ns/1ps

module pattern_sequencer
    import emu_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              start_i,
    output logic [RAM_AW-1:0] addr_a_o,
    input  logic [CFG_DW-1:0] q_a_i,
    pattern_if.seq            ent,
    output logic              clear_o,
    output logic              done_o
);
    seq_state_e        state;
    seq_state_e        state_next;
    logic [RAM_AW-1:0] addr_next;
    logic [REPEAT_W-1:0] repeat_cnt;
    logic [REPEAT_W-1:0] repeat_next;
    logic              last_entry;
    logic              start_ok;

    // the current ram word is the current entry
    assign {ent.pck_num, ent.ratio, ent.size, ent.dest, ent.pck_class, last_entry} = q_a_i;

    assign ent.entry_valid = (state == SEND);
    assign start_ok        = start_i && (state == IDLE || state == DONE);
    assign clear_o         = start_ok;   // new run, fresh statistics
    assign done_o          = (state == DONE);

    always_comb begin
        state_next  = state;
        addr_next   = addr_a_o;
        repeat_next = repeat_cnt;
        case (state)
            IDLE, DONE: begin
                if (start_ok) begin
                    repeat_next = q_a_i[REPEAT_W-1:0];   // addr is on word 0 here
                    addr_next   = PATTERN_START_ADDR;
                    state_next  = WAIT1;
                end
            end
            WAIT1: state_next = WAIT2;
            WAIT2: state_next = SEND;
            SEND: begin
                if (ent.entry_done) begin
                    if (!last_entry) begin
                        addr_next  = addr_a_o + 1'b1;
                        state_next = WAIT1;
                    end else if (repeat_cnt != '0) begin
                        // wrap for another pass
                        addr_next   = PATTERN_START_ADDR;
                        repeat_next = repeat_cnt - 1'b1;
                        state_next  = WAIT1;
                    end else begin
                        addr_next  = REPEAT_ADDR;   // ready for a restart
                        state_next = DONE;
                    end
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            addr_a_o   <= REPEAT_ADDR;
            repeat_cnt <= '0;
        end else begin
            state      <= state_next;
            addr_a_o   <= addr_next;
            repeat_cnt <= repeat_next;
        end
    end

endmodule

// ==== verilog/packet_injector.sv ====
`timescale 1ns/1ps

module packet_injector
    import emu_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    pattern_if.inj              ent,
    input  logic [DEST_W-1:0]   endp_addr_i,
    output logic                pck_valid_o,
    output logic [DEST_W-1:0]   pck_dest_o,
    output logic [CLASS_W-1:0]  pck_class_o,
    output logic [PCK_SIZW-1:0] pck_size_o,
    output logic                sent_o
);
    logic [RATIOW:0]     acc;       // always below MAX_RATIO between cycles
    logic [RATIOW:0]     acc_sum;
    logic [PCK_CNTW-1:0] pck_cnt;
    logic [PCK_SIZW-1:0] gap_cnt;   // idle cycles left after a packet
    logic                self_dest;
    logic                fire;

    assign self_dest = (ent.dest == endp_addr_i);
    assign acc_sum   = acc + {1'b0, ent.ratio};

    // covers pck_num of 0 too, since the counter starts at 0
    assign ent.entry_done = ent.entry_valid && (self_dest || pck_cnt == ent.pck_num);

    assign fire = ent.entry_valid && !ent.entry_done && (gap_cnt == '0)
                  && (acc_sum >= MAX_RATIO);

    assign pck_valid_o = fire;
    assign sent_o      = fire;
    assign pck_dest_o  = ent.dest;
    assign pck_class_o = ent.pck_class;
    assign pck_size_o  = ent.size;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc     <= '0;
            pck_cnt <= '0;
            gap_cnt <= '0;
        end else if (!ent.entry_valid) begin
            acc     <= '0;   // fresh start for each entry
            pck_cnt <= '0;
            gap_cnt <= '0;
        end else if (gap_cnt != '0) begin
            gap_cnt <= gap_cnt - 1'b1;   // pacing, no accumulation
        end else if (!ent.entry_done) begin
            if (acc_sum >= MAX_RATIO) begin
                acc     <= acc_sum - MAX_RATIO;
                pck_cnt <= pck_cnt + 1'b1;
                // size 0 behaves as size 1
                gap_cnt <= (ent.size == '0) ? '0 : ent.size - 1'b1;
            end else begin
                acc <= acc_sum;
            end
        end
    end

endmodule

// ==== verilog/traffic_stats.sv ====
`timescale 1ns/1ps

module traffic_stats
    import emu_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               clear_i,
    input  logic               sent_i,
    input  logic               rx_valid_i,
    input  logic [LAT_W-1:0]   rx_latency_i,
    input  logic [STAT_AW-1:0] stat_addr_i,
    output logic [CFG_DW-1:0]  stat_q_o
);
    logic [CFG_DW-1:0] sent_cnt;
    logic [CFG_DW-1:0] rcvd_cnt;
    logic [CFG_DW-1:0] lat_sum;
    logic [LAT_W-1:0]  worst_lat;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sent_cnt  <= '0;
            rcvd_cnt  <= '0;
            lat_sum   <= '0;
            worst_lat <= '0;
        end else if (clear_i) begin
            sent_cnt  <= '0;
            rcvd_cnt  <= '0;
            lat_sum   <= '0;
            worst_lat <= '0;
        end else begin
            if (sent_i) sent_cnt <= sent_cnt + 1'b1;
            if (rx_valid_i) begin
                rcvd_cnt <= rcvd_cnt + 1'b1;
                lat_sum  <= lat_sum + rx_latency_i;
                if (rx_latency_i > worst_lat) worst_lat <= rx_latency_i;   // running max
            end
        end
    end

    // host readout
    always_comb begin
        stat_q_o = '0;
        case (stat_addr_i)
            STAT_SENT:      stat_q_o = sent_cnt;
            STAT_RCVD:      stat_q_o = rcvd_cnt;
            STAT_TOTAL_LAT: stat_q_o = lat_sum;
            STAT_WORST_LAT: stat_q_o = {{(CFG_DW - LAT_W){1'b0}}, worst_lat};
        endcase
    end

endmodule

// ==== verilog/traffic_emulator.sv ====
`timescale 1ns/1ps

module traffic_emulator
    import emu_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start_i,
    output logic                done_o,
    input  logic [DEST_W-1:0]   endp_addr_i,
    // host access to the pattern table
    input  logic                cfg_we_i,
    input  logic [RAM_AW-1:0]   cfg_addr_i,
    input  logic [CFG_DW-1:0]   cfg_data_i,
    output logic [CFG_DW-1:0]   cfg_q_o,
    // packet output toward the network
    output logic                pck_valid_o,
    output logic [DEST_W-1:0]   pck_dest_o,
    output logic [CLASS_W-1:0]  pck_class_o,
    output logic [PCK_SIZW-1:0] pck_size_o,
    // receive side
    input  logic                rx_valid_i,
    input  logic [LAT_W-1:0]    rx_latency_i,
    input  logic [STAT_AW-1:0]  stat_addr_i,
    output logic [CFG_DW-1:0]   stat_q_o
);
    logic [RAM_AW-1:0] seq_addr;
    logic [CFG_DW-1:0] seq_q;
    logic              stats_clear;
    logic              pck_sent;

    pattern_if ent ();

    pattern_ram u_ram (
        .clk      (clk),
        .addr_a_i (seq_addr),
        .q_a_o    (seq_q),
        .we_b_i   (cfg_we_i),
        .addr_b_i (cfg_addr_i),
        .data_b_i (cfg_data_i),
        .q_b_o    (cfg_q_o)
    );

    pattern_sequencer u_seq (
        .clk      (clk),
        .reset    (reset),
        .start_i  (start_i),
        .addr_a_o (seq_addr),
        .q_a_i    (seq_q),
        .ent      (ent.seq),
        .clear_o  (stats_clear),
        .done_o   (done_o)
    );

    packet_injector u_inj (
        .clk         (clk),
        .reset       (reset),
        .ent         (ent.inj),
        .endp_addr_i (endp_addr_i),
        .pck_valid_o (pck_valid_o),
        .pck_dest_o  (pck_dest_o),
        .pck_class_o (pck_class_o),
        .pck_size_o  (pck_size_o),
        .sent_o      (pck_sent)
    );

    traffic_stats u_stats (
        .clk          (clk),
        .reset        (reset),
        .clear_i      (stats_clear),
        .sent_i       (pck_sent),
        .rx_valid_i   (rx_valid_i),
        .rx_latency_i (rx_latency_i),
        .stat_addr_i  (stat_addr_i),
        .stat_q_o     (stat_q_o)
    );

endmodule

// ==== test/emu_sva.sv ====
`timescale 1ns/1ps

module emu_sva (
    input logic clk_i,
    input logic reset_i,
    input logic entry_valid_i,
    input logic entry_done_i,
    input logic pck_valid_i,
    input logic self_dest_i,
    input logic done_i
);
    int fails = 0;

    assert property (@(posedge clk_i) disable iff (reset_i) !(pck_valid_i && self_dest_i))
    else begin
        fails++;
        $error("packet sent to the endpoint's own address");
    end

    // one-cycle pulse, the sequencer leaves SEND right after it
    assert property (@(posedge clk_i) disable iff (reset_i)
        entry_done_i |-> entry_valid_i ##1 !entry_valid_i)
    else begin
        fails++;
        $error("entry_done outside a single SEND cycle");
    end

    assert property (@(posedge clk_i) disable iff (reset_i) done_i |-> !pck_valid_i)
    else begin
        fails++;
        $error("packet sent while done_o is high");
    end

endmodule

bind packet_injector emu_sva inj_sva (
    .clk_i(clk), .reset_i(reset), .entry_valid_i(ent.entry_valid),
    .entry_done_i(ent.entry_done), .pck_valid_i(pck_valid_o),
    .self_dest_i(ent.dest == endp_addr_i), .done_i(1'b0)
);

bind pattern_sequencer emu_sva seq_sva (
    .clk_i(clk), .reset_i(reset), .entry_valid_i(ent.entry_valid),
    .entry_done_i(ent.entry_done), .pck_valid_i(u_inj.pck_valid_o), .self_dest_i(1'b0),
    .done_i(done_o)
);

// ==== test/emu_checker.sv ====
`timescale 1ns/1ps

module emu_checker
    import emu_pkg::*;
(
    input logic                clk_i,
    input logic                reset_i,
    input logic                pck_valid_i,
    input logic [DEST_W-1:0]   pck_dest_i,
    input logic [CLASS_W-1:0]  pck_class_i,
    input logic [PCK_SIZW-1:0] pck_size_i
);
    localparam int PW = DEST_W + CLASS_W + PCK_SIZW;

    logic [PW-1:0] exp_q [$];   // {dest, class, size}
    logic [PW-1:0] exp_pck;
    int test_errs = 0;
    int total_errs = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle = 0;
    int last_cycle = -1;
    int gap;
    int gap_min = 0;
    int gap_max = 0;

    task automatic expect_packet(input logic [PW-1:0] p);
        exp_q.push_back(p);
    endtask

    task automatic clear_spacing();
        last_cycle = -1;
        gap_min = 0;
        gap_max = 0;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
            input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_spacing(input int exp);
        if (gap_min != exp || gap_max != exp) begin
            $display("FAIL pck_valid_o spacing: got %h to %h, expected %h", gap_min, gap_max, exp);
            test_errs++;
        end
    endtask

    // done_o may only rise once every expected packet went out
    task automatic check_all_sent();
        if (exp_q.size() != 0) begin
            $display("done_o rose with %0d packets still unsent", exp_q.size());
            test_errs++;
        end
    endtask

    task automatic begin_test();
        test_errs = 0;
        exp_q.delete();
        clear_spacing();
    endtask

    task automatic end_test(input string name);
        if (exp_q.size() != 0) begin
            $display("%0d expected packets never appeared", exp_q.size());
            test_errs++;
            exp_q.delete();
        end
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errs);
        end
    endtask

    task automatic report();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
    endtask

    // outputs settle mid-cycle, so compare on the falling edge
    always @(negedge clk_i) begin
        cycle = cycle + 1;
        if (!reset_i && pck_valid_i) begin
            if (exp_q.size() == 0) begin
                $display("packet to dest %h arrived with none expected", pck_dest_i);
                test_errs++;
            end else begin
                exp_pck = exp_q.pop_front();
                check_value("pck_dest_o", 64'(pck_dest_i), 64'(exp_pck[PW-1 -: DEST_W]));
                check_value("pck_class_o", 64'(pck_class_i),
                            64'(exp_pck[PCK_SIZW +: CLASS_W]));
                check_value("pck_size_o", 64'(pck_size_i), 64'(exp_pck[PCK_SIZW-1:0]));
            end
            if (last_cycle >= 0) begin
                gap = cycle - last_cycle;
                if (gap_min == 0 || gap < gap_min) gap_min = gap;
                if (gap > gap_max) gap_max = gap;
            end
            last_cycle = cycle;
        end
    end

endmodule

// ==== test/tb_traffic_emulator.sv ====
`timescale 1ns/1ps

module tb_traffic_emulator
    import emu_pkg::*;
();
    localparam int PW        = DEST_W + CLASS_W + PCK_SIZW;
    localparam int CLS_LO    = 1;
    localparam int DEST_LO   = CLS_LO + CLASS_W;
    localparam int SIZE_LO   = DEST_LO + DEST_W;
    localparam int RATIO_LO  = SIZE_LO + PCK_SIZW;
    localparam int CNT_LO    = RATIO_LO + RATIOW;
    localparam int NET_DELAY = 3;      // network transit, in cycles
    localparam int TIMEOUT   = 2000;
    localparam logic [DEST_W-1:0] ENDP = 8'hc5;

    logic clk = 1'b0;
    logic reset, start, done, cfg_we, pck_valid;
    logic [DEST_W-1:0] endp_addr, pck_dest;
    logic [RAM_AW-1:0] cfg_addr;
    logic [CFG_DW-1:0] cfg_data, cfg_q, stat_q;
    logic [CLASS_W-1:0] pck_class;
    logic [PCK_SIZW-1:0] pck_size;
    logic rx_valid = 1'b0;
    logic [LAT_W-1:0] rx_latency = '0;
    logic [STAT_AW-1:0] stat_addr;

    logic [CFG_DW-1:0] tbl [0:(1 << RAM_AW) - 1];   // host copy of the pattern table
    logic [PW-1:0] exp_pkts [$];
    logic [LAT_W-1:0] lat_plan [$];    // latency the network gives each packet
    logic [LAT_W-1:0] rx_lat [$];
    int rx_due [$];
    int net_cycle = 0;
    logic [31:0] rng = 32'h9426;
    logic [63:0] ref_sent, ref_lat_sum;
    logic [LAT_W-1:0] ref_worst;

    traffic_emulator uut (
        .clk(clk), .reset(reset), .start_i(start), .done_o(done), .endp_addr_i(endp_addr),
        .cfg_we_i(cfg_we), .cfg_addr_i(cfg_addr), .cfg_data_i(cfg_data), .cfg_q_o(cfg_q),
        .pck_valid_o(pck_valid), .pck_dest_o(pck_dest), .pck_class_o(pck_class),
        .pck_size_o(pck_size), .rx_valid_i(rx_valid), .rx_latency_i(rx_latency),
        .stat_addr_i(stat_addr), .stat_q_o(stat_q)
    );

    emu_checker chk (
        .clk_i(clk), .reset_i(reset), .pck_valid_i(pck_valid), .pck_dest_i(pck_dest),
        .pck_class_i(pck_class), .pck_size_i(pck_size)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [CFG_DW-1:0] make_entry(input int cnt, input int ratio,
            input int size, input logic [DEST_W-1:0] dest, input logic [CLASS_W-1:0] cls,
            input logic last);
        return {cnt[PCK_CNTW-1:0], ratio[RATIOW-1:0], size[PCK_SIZW-1:0], dest, cls, last};
    endfunction

    // expected packets in order, with a planned latency for each
    function automatic void ref_run(input logic [DEST_W-1:0] endp);
        int passes;
        int a;
        logic [CFG_DW-1:0] w;
        logic stop;
        logic [LAT_W-1:0] lat;
        exp_pkts.delete();
        lat_plan.delete();
        ref_sent = '0;
        ref_lat_sum = '0;
        ref_worst = '0;
        passes = int'(tbl[REPEAT_ADDR][REPEAT_W-1:0]) + 1;
        for (int p = 0; p < passes; p++) begin
            a = 1;
            stop = 1'b0;
            while (!stop && a < (1 << RAM_AW)) begin
                w = tbl[a];
                if (w[DEST_LO +: DEST_W] != endp) begin   // own address is skipped
                    for (int k = 0; k < int'(w[CNT_LO +: PCK_CNTW]); k++) begin
                        exp_pkts.push_back({w[DEST_LO +: DEST_W], w[CLS_LO +: CLASS_W],
                                            w[SIZE_LO +: PCK_SIZW]});
                        rng = lcg_next(rng);
                        lat = {8'h00, rng[23:16]} + 16'd1;
                        lat_plan.push_back(lat);
                        ref_sent = ref_sent + 64'd1;
                        ref_lat_sum = ref_lat_sum + 64'(lat);
                        if (lat > ref_worst) ref_worst = lat;
                    end
                end
                stop = w[0];
                a++;
            end
        end
    endfunction

    // network stand-in, returns every packet NET_DELAY cycles later
    always @(negedge clk) begin
        net_cycle = net_cycle + 1;
        rx_valid = 1'b0;
        if (rx_due.size() != 0 && rx_due[0] <= net_cycle) begin
            rx_valid = 1'b1;
            rx_latency = rx_lat.pop_front();
            void'(rx_due.pop_front());
        end
        if (!reset && pck_valid) begin
            rx_due.push_back(net_cycle + NET_DELAY);
            if (lat_plan.size() != 0) rx_lat.push_back(lat_plan.pop_front());
            else rx_lat.push_back('0);
        end
    end

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s did not happen in time", what);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic build_basic_table(input int extra);
        logic [DEST_W-1:0] d;
        tbl[0] = CFG_DW'(extra);
        for (int e = 1; e <= 3; e++) begin
            rng = lcg_next(rng);
            d = {1'b0, rng[14:8]};   // bit 7 clear, never ENDP
            tbl[e] = make_entry(e + 1, 100, 1, d, rng[19:16], e == 3);
        end
    endtask

    task automatic write_table(input int words);
        for (int a = 0; a < words; a++) begin
            @(negedge clk);
            cfg_we = 1'b1;
            cfg_addr = RAM_AW'(a);
            cfg_data = tbl[a];
        end
        @(negedge clk);
        cfg_we = 1'b0;
        repeat (2) @(negedge clk);   // port a must see the new word 0
    endtask

    task automatic read_stat(input logic [STAT_AW-1:0] a, input string name,
            input logic [63:0] exp);
        @(negedge clk);
        stat_addr = a;
        @(negedge clk);
        chk.check_value(name, stat_q, exp);
    endtask

    task automatic run_table(input logic [DEST_W-1:0] endp);
        int n;
        ref_run(endp);
        foreach (exp_pkts[i]) chk.expect_packet(exp_pkts[i]);
        chk.clear_spacing();
        @(negedge clk);
        endp_addr = endp;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        n = 0;
        while (!done && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!done) abort_on_timeout("done_o");
        chk.check_all_sent();
        n = 0;
        while ((rx_due.size() != 0 || rx_valid) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (rx_due.size() != 0) abort_on_timeout("return of all packets");
        read_stat(STAT_SENT, "stat_q_o sent", ref_sent);
        read_stat(STAT_RCVD, "stat_q_o received", ref_sent);
        read_stat(STAT_TOTAL_LAT, "stat_q_o total latency", ref_lat_sum);
        read_stat(STAT_WORST_LAT, "stat_q_o worst latency", 64'(ref_worst));
    endtask

    initial begin
        int sva_fails;
        reset = 1'b1;
        start = 1'b0;
        endp_addr = ENDP;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        stat_addr = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        chk.begin_test();
        build_basic_table(0);
        write_table(4);
        for (int a = 0; a <= 4; a++) begin   // address in, word out one cycle later
            @(negedge clk);
            if (a > 0) chk.check_value("cfg_q_o", cfg_q, tbl[a - 1]);
            if (a < 4) cfg_addr = RAM_AW'(a);
        end
        chk.end_test("table readback");

        chk.begin_test();
        run_table(ENDP);
        chk.end_test("three entries");

        chk.begin_test();
        build_basic_table(2);
        write_table(4);
        run_table(ENDP);
        chk.end_test("two repeats");

        chk.begin_test();
        tbl[0] = '0;
        tbl[1] = make_entry(3, 100, 1, ENDP, 4'h2, 1'b0);
        tbl[2] = make_entry(0, 100, 1, 8'h11, 4'h3, 1'b0);
        tbl[3] = make_entry(2, 100, 2, 8'h22, 4'h4, 1'b1);
        write_table(4);
        run_table(ENDP);
        chk.end_test("skipped entries");

        chk.begin_test();
        tbl[1] = make_entry(5, 50, 1, 8'h33, 4'h1, 1'b1);
        write_table(2);
        run_table(ENDP);
        chk.check_spacing(2);
        tbl[1] = make_entry(4, 100, 3, 8'h44, 4'h5, 1'b1);
        write_table(2);
        run_table(ENDP);
        chk.check_spacing(3);
        chk.end_test("injection pacing");

        chk.begin_test();
        build_basic_table(1);
        write_table(4);
        run_table(ENDP);
        tbl[0] = '0;
        tbl[1] = make_entry(2, 100, 1, ENDP, 4'h0, 1'b1);   // nothing sent, all stats zero
        write_table(2);
        run_table(ENDP);
        chk.end_test("statistics and restart");

        sva_fails = uut.u_inj.inj_sva.fails + uut.u_seq.seq_sva.fails;
        if (sva_fails != 0) $display("%0d assertion failures", sva_fails);
        chk.report();
        if (chk.total_errs == 0 && sva_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== files.f ====
verilog/emu_pkg.sv
verilog/pattern_if.sv
verilog/pattern_ram.sv
verilog/pattern_sequencer.sv
verilog/packet_injector.sv
verilog/traffic_stats.sv
verilog/traffic_emulator.sv
test/emu_sva.sv
test/emu_checker.sv
test/tb_traffic_emulator.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_traffic_emulator
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES  := $(shell grep -v '^+' $(FILELIST))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)
PASS_MSG := *** TEST PASSED ***

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
